/* verilog/aesPkg.sv */
`default_nettype none

package aesPkg;

	typedef logic [7:0] aesByte;

	// Byte 0 is the most significant byte. The state is stored column by column.
	typedef logic [0:15][7:0] aesBlock;

	// ========================================================================
	// Substitution tables
	// ========================================================================

	localparam logic [0:255][7:0] sBox = {
		256'h637c777bf26b6fc53001672bfed7ab76ca82c97dfa5947f0add4a2af9ca472c0,
		256'hb7fd9326363ff7cc34a5e5f171d8311504c723c31896059a071280e2eb27b275,
		256'h09832c1a1b6e5aa0523bd6b329e32f8453d100ed20fcb15b6acbbe394a4c58cf,
		256'hd0efaafb434d338545f9027f503c9fa851a3408f929d38f5bcb6da2110fff3d2,
		256'hcd0c13ec5f974417c4a77e3d645d197360814fdc222a908846eeb814de5e0bdb,
		256'he0323a0a4906245cc2d3ac629195e479e7c8376d8dd54ea96c56f4ea657aae08,
		256'hba78252e1ca6b4c6e8dd741f4bbd8b8a703eb5664803f60e613557b986c11d9e,
		256'he1f8981169d98e949b1e87e9ce5528df8ca1890dbfe6426841992d0fb054bb16
	};

	localparam logic [0:255][7:0] invSBox = {
		256'h52096ad53036a538bf40a39e81f3d7fb7ce339829b2fff87348e4344c4dee9cb,
		256'h547b9432a6c2233dee4c950b42fac34e082ea16628d924b2765ba2496d8bd125,
		256'h72f8f66486689816d4a45ccc5d65b6926c704850fdedb9da5e154657a78d9d84,
		256'h90d8ab008cbcd30af7e45805b8b34506d02c1e8fca3f0f02c1afbd0301138a6b,
		256'h3a9111414f67dcea97f2cfcef0b4e67396ac7422e7ad3585e2f937e81c75df6e,
		256'h47f11a711d29c5896fb7620eaa18be1bfc563e4bc6d279209adbc0fe78cd5af4,
		256'h1fdda8338807c731b11210592780ec5f60517fa919b54a0d2de57a9f93c99cef,
		256'ha0e03b4dae2af5b0c8ebbb3c83539961172b047eba77d626e169146355210c7d
	};

	// ========================================================================
	// GF(2^8) arithmetic
	// ========================================================================

	// Multiply by x, reducing by the AES polynomial x^8 + x^4 + x^3 + x + 1.
	function automatic aesByte xtime(input aesByte value);
		return {value[6:0], 1'b0} ^ (value[7] ? 8'h1b : 8'h00);
	endfunction

	// Multiply by a constant below 16, enough for both column mixes.
	function automatic aesByte gfMul(input aesByte value, input logic [3:0] factor);
		aesByte acc;
		aesByte power;
		acc = 8'h00;
		power = value;
		for (int i = 0; i < 4; i++)
		begin
			if (factor[i])
				acc = acc ^ power;
			power = xtime(power);
		end
		return acc;
	endfunction

endpackage

`default_nettype wire

/* verilog/aesCtrlPkg.sv */
`default_nettype none

package aesCtrlPkg;

	typedef logic [3:0] roundIndex;

	localparam roundIndex numRounds = 4'd10;

	// Cycles from the expand strobe until the last round key is stored.
	localparam roundIndex expandCycles = 4'd10;

	// Accepted start to done, in clock cycles.
	localparam int cipherLatency = 50;

	typedef enum logic [3:0] {
		stepIdle,
		stepLoadKey,
		stepSubBytes,
		stepShiftRows,
		stepMixColumns,
		stepAddKey,
		stepInvSubBytes,
		stepInvShiftRows,
		stepInvMixColumns,
		stepFinish
	} roundStep;

endpackage

`default_nettype wire

/* verilog/aesIfs.sv */
`default_nettype none

// Round key lookup between the sequencer and the key store.
interface keyScheduleIf;
	logic expandStart;
	aesCtrlPkg::roundIndex keyIndex;
	aesPkg::aesBlock roundKey;
	logic ready;

	modport sequencer (output expandStart, output keyIndex, input roundKey, input ready);
	modport schedule (input expandStart, input keyIndex, output roundKey, output ready);
endinterface

// Step command and key from the sequencer, state block back from the datapath.
interface roundStepIf;
	aesCtrlPkg::roundStep step;
	aesPkg::aesBlock roundKey;
	aesPkg::aesBlock result;

	modport sequencer (output step, output roundKey, input result);
	modport datapath (input step, input roundKey, output result);
endinterface

`default_nettype wire

/* verilog/aesKeyExpansion.sv */
`default_nettype none

module aesKeyExpansion (
	input logic clock,
	input logic reset,
	keyScheduleIf.schedule keyPort,
	input aesPkg::aesBlock key
);
	import aesPkg::*;
	import aesCtrlPkg::*;

	aesBlock roundKeys [0:numRounds];
	aesBlock prevKey;
	aesBlock nextKey;
	logic [0:3][7:0] temp;
	roundIndex count;
	aesByte rcon;
	logic keysReady;

	// One AES-128 schedule step. The last word is rotated, substituted and salted with rcon.
	always_comb
	begin
		prevKey = roundKeys[count - 4'd1];
		temp = {sBox[prevKey[13]] ^ rcon, sBox[prevKey[14]], sBox[prevKey[15]], sBox[prevKey[12]]};
		nextKey[0:3] = prevKey[0:3] ^ temp;
		nextKey[4:7] = prevKey[4:7] ^ nextKey[0:3];
		nextKey[8:11] = prevKey[8:11] ^ nextKey[4:7];
		nextKey[12:15] = prevKey[12:15] ^ nextKey[8:11];
	end

	// A nonzero count means a schedule is running and names the key being written.
	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			count <= '0;
			keysReady <= 1'b0;
		end
		else if (keyPort.expandStart)
		begin
			count <= 4'd1;
			keysReady <= 1'b0;
		end
		else if (count != '0)
		begin
			if (count == expandCycles)
			begin
				count <= '0;
				keysReady <= 1'b1;
			end
			else
				count <= count + 4'd1;
		end
	end

	always_ff @(posedge clock)
	begin
		if (keyPort.expandStart)
		begin
			roundKeys[0] <= key;
			rcon <= 8'h01;
		end
		else if (count != '0)
		begin
			roundKeys[count] <= nextKey;
			rcon <= xtime(rcon);
		end
	end

	assign keyPort.roundKey = roundKeys[keyPort.keyIndex];
	assign keyPort.ready = keysReady;

endmodule

`default_nettype wire

/* verilog/aesRoundUnit.sv */
`default_nettype none

module aesRoundUnit (
	input logic clock,
	input logic reset,
	roundStepIf.datapath stepPort,
	input aesPkg::aesBlock messageIn,
	output aesPkg::aesBlock messageOut
);
	import aesPkg::*;
	import aesCtrlPkg::*;

	aesBlock stateBlock;

	// ========================================================================
	// Block transforms
	// ========================================================================

	function automatic aesBlock subBlock(input aesBlock value, input logic inverse);
		aesBlock result;
		for (int i = 0; i < 16; i++)
			result[i] = inverse ? invSBox[value[i]] : sBox[value[i]];
		return result;
	endfunction

	// Row r rotates left by r columns, or right by r for the inverse.
	function automatic aesBlock shiftBlock(input aesBlock value, input logic inverse);
		aesBlock result;
		int src;
		for (int c = 0; c < 4; c++)
		begin
			for (int r = 0; r < 4; r++)
			begin
				src = inverse ? (c + 4 - r) % 4 : (c + r) % 4;
				result[r + 4 * c] = value[r + 4 * src];
			end
		end
		return result;
	endfunction

	// Each column is multiplied by a circulant matrix, whose first row is coef.
	function automatic aesBlock mixBlock(input aesBlock value, input logic inverse);
		aesBlock result;
		logic [0:3][3:0] coef;
		coef = inverse ? {4'he, 4'hb, 4'hd, 4'h9} : {4'h2, 4'h3, 4'h1, 4'h1};
		for (int c = 0; c < 4; c++)
		begin
			for (int r = 0; r < 4; r++)
			begin
				result[r + 4 * c] = 8'h00;
				for (int j = 0; j < 4; j++)
					result[r + 4 * c] ^= gfMul(value[j + 4 * c], coef[(j + 4 - r) % 4]);
			end
		end
		return result;
	endfunction

	// ========================================================================
	// State register
	// ========================================================================

	always_ff @(posedge clock)
	begin
		case (stepPort.step)
			stepLoadKey:
				stateBlock <= messageIn ^ stepPort.roundKey;
			stepSubBytes:
				stateBlock <= subBlock(stateBlock, 1'b0);
			stepShiftRows:
				stateBlock <= shiftBlock(stateBlock, 1'b0);
			stepMixColumns:
				stateBlock <= mixBlock(stateBlock, 1'b0);
			stepAddKey:
				stateBlock <= stateBlock ^ stepPort.roundKey;
			stepInvSubBytes:
				stateBlock <= subBlock(stateBlock, 1'b1);
			stepInvShiftRows:
				stateBlock <= shiftBlock(stateBlock, 1'b1);
			stepInvMixColumns:
				stateBlock <= mixBlock(stateBlock, 1'b1);
			default:
				stateBlock <= stateBlock;
		endcase
	end

	// The last key addition goes straight to the output, which then holds until the next run.
	always_ff @(posedge clock)
	begin
		if (reset)
			messageOut <= '0;
		else if (stepPort.step == stepFinish)
			messageOut <= stateBlock ^ stepPort.roundKey;
	end

	assign stepPort.result = stateBlock;

endmodule

`default_nettype wire

/* verilog/aesController.sv */
`default_nettype none

module aesController (
	input logic clock,
	input logic reset,
	input logic start,
	input logic encrypt,
	keyScheduleIf.sequencer keyPort,
	roundStepIf.sequencer stepPort,
	output logic done
);
	import aesCtrlPkg::*;

	roundStep stepReg;
	roundStep curStep;
	roundStep nextStep;
	roundIndex round;
	logic busy;
	logic encryptMode;
	logic accept;
	logic lastRound;
	logic roundEnd;

	assign accept = start && !busy;
	assign lastRound = (round == numRounds);
	assign roundEnd = (curStep == stepAddKey && encryptMode) || curStep == stepInvMixColumns;

	// ========================================================================
	// Step sequencing
	// ========================================================================

	// The load step goes out in the first cycle that ready is high, so no cycle is lost.
	always_comb
	begin
		curStep = stepReg;
		if (busy && stepReg == stepIdle && keyPort.ready)
			curStep = stepLoadKey;
	end

	always_comb
	begin
		case (curStep)
			stepLoadKey:
				nextStep = encryptMode ? stepSubBytes : stepInvShiftRows;
			stepSubBytes:
				nextStep = stepShiftRows;
			stepShiftRows:
				nextStep = lastRound ? stepFinish : stepMixColumns;
			stepMixColumns:
				nextStep = stepAddKey;
			stepAddKey:
				nextStep = encryptMode ? stepSubBytes : stepInvMixColumns;
			stepInvShiftRows:
				nextStep = stepInvSubBytes;
			stepInvSubBytes:
				nextStep = lastRound ? stepFinish : stepAddKey;
			stepInvMixColumns:
				nextStep = stepInvShiftRows;
			default:
				nextStep = stepIdle;
		endcase
	end

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			stepReg <= stepIdle;
			round <= '0;
			busy <= 1'b0;
			encryptMode <= 1'b1;
			done <= 1'b0;
		end
		else if (accept)
		begin
			stepReg <= stepIdle;
			round <= '0;
			busy <= 1'b1;
			encryptMode <= encrypt;
			done <= 1'b0;
		end
		else if (busy)
		begin
			stepReg <= nextStep;
			if (curStep == stepLoadKey)
				round <= 4'd1;
			else if (roundEnd)
				round <= round + 4'd1;
			if (curStep == stepFinish)
			begin
				busy <= 1'b0;
				done <= 1'b1;
			end
		end
	end

	// Decryption walks the key store from the top down.
	assign keyPort.expandStart = accept;
	assign keyPort.keyIndex = encryptMode ? round : numRounds - round;
	assign stepPort.step = curStep;
	assign stepPort.roundKey = keyPort.roundKey;

endmodule

`default_nettype wire

/* verilog/aesCore.sv */
`default_nettype none

module aesCore (
	input logic clock,
	input logic reset,
	input logic start,
	input logic encrypt,
	input aesPkg::aesBlock key,
	input aesPkg::aesBlock messageIn,
	output logic done,
	output aesPkg::aesBlock messageOut
);

	keyScheduleIf keyBus ();
	roundStepIf stepBus ();

	aesKeyExpansion keyExpansion_i (
		.clock(clock),
		.reset(reset),
		.keyPort(keyBus.schedule),
		.key(key)
	);

	aesController controller_i (
		.clock(clock),
		.reset(reset),
		.start(start),
		.encrypt(encrypt),
		.keyPort(keyBus.sequencer),
		.stepPort(stepBus.sequencer),
		.done(done)
	);

	aesRoundUnit roundUnit_i (
		.clock(clock),
		.reset(reset),
		.stepPort(stepBus.datapath),
		.messageIn(messageIn),
		.messageOut(messageOut)
	);

endmodule

`default_nettype wire

/* sim/aesCore_props.sv */
`default_nettype none

module aesCoreProps (
	input logic clock,
	input logic reset,
	input logic start,
	input logic done
);
	timeunit 1ns;
	timeprecision 100ps;
	import aesCtrlPkg::*;

	logic started;
	logic accepted;
	int resetFails = 0;
	int fallFails = 0;
	int latencyFails = 0;

	// The core is busy from an accepted start until done comes up.
	assign accepted = start && !(started && !done);

	always @(posedge clock)
	begin
		if (reset)
			started <= 1'b0;
		else if (accepted)
			started <= 1'b1;
	end

	doneLowAfterReset: assert property (@(posedge clock) reset |=> !done)
		else
		begin
			resetFails++;
			$error("done was high in the cycle after reset");
		end

	doneFallsOnStart: assert property (@(posedge clock) disable iff (reset)
		accepted |=> !done)
		else
		begin
			fallFails++;
			$error("done did not fall after an accepted start");
		end

	// Done is driven at the cipherLatency edge, so its sampled value rises one edge later.
	doneAtLatency: assert property (@(posedge clock) disable iff (reset)
		accepted |=> ##cipherLatency $rose(done))
		else
		begin
			latencyFails++;
			$error("done did not rise at the cipher latency");
		end

endmodule

`default_nettype wire

/* sim/aesCoreTb.sv */
`default_nettype none

module aesCoreTb;
	timeunit 1ns;
	timeprecision 100ps;
	import aesPkg::*;

	localparam aesBlock fipsKey = 128'h000102030405060708090a0b0c0d0e0f;
	localparam aesBlock fipsPlain = 128'h00112233445566778899aabbccddeeff;
	localparam aesBlock fipsCipher = 128'h69c4e0d86a7b0430d8cdb78070b4c55a;
	localparam int expectedLatency = 50;

	// Two known vectors, sixteen encryptions, sixteen round trips and one interrupted run.
	localparam int runsPlanned = 51;
	localparam int cycleLimit = runsPlanned * (expectedLatency + 5) + 200;

	logic clock;
	logic reset;
	logic start;
	logic encrypt;
	aesBlock key;
	aesBlock messageIn;
	logic done;
	aesBlock messageOut;
	logic [31:0] lcgState;
	int cycleCount = 0;

	aesCore dut_i (
		.clock(clock),
		.reset(reset),
		.start(start),
		.encrypt(encrypt),
		.key(key),
		.messageIn(messageIn),
		.done(done),
		.messageOut(messageOut)
	);

	bind aesCore aesCoreProps props_i (
		.clock(clock),
		.reset(reset),
		.start(start),
		.done(done)
	);

	initial
	begin
		clock = 1'b0;
		forever #4 clock = ~clock;
	end

	// ========================================================================
	// Reference model and random data
	// ========================================================================

	function automatic logic [31:0] nextRandom();
		lcgState = lcgState * 32'd1664525 + 32'd1013904223;
		return lcgState;
	endfunction

	function automatic aesBlock randomBlock();
		return {nextRandom(), nextRandom(), nextRandom(), nextRandom()};
	endfunction

	// AES-128 encryption on a flat byte array. Byte r + 4c is row r of column c.
	function automatic aesBlock aesEncryptRef(input aesBlock keyIn, input aesBlock plain);
		aesByte w [0:175];
		aesByte s [0:15];
		aesByte t [0:15];
		aesByte rc;
		aesBlock out;
		rc = 8'h01;
		for (int i = 0; i < 16; i++)
			w[i] = keyIn[i];
		for (int i = 16; i < 176; i += 4)
		begin
			if (i % 16 == 0)
			begin
				w[i] = w[i - 16] ^ sBox[w[i - 3]] ^ rc;
				w[i + 1] = w[i - 15] ^ sBox[w[i - 2]];
				w[i + 2] = w[i - 14] ^ sBox[w[i - 1]];
				w[i + 3] = w[i - 13] ^ sBox[w[i - 4]];
				rc = xtime(rc);
			end
			else
			begin
				for (int j = 0; j < 4; j++)
					w[i + j] = w[i - 16 + j] ^ w[i - 4 + j];
			end
		end
		for (int i = 0; i < 16; i++)
			s[i] = plain[i] ^ w[i];
		for (int round = 1; round <= 10; round++)
		begin
			for (int i = 0; i < 16; i++)
				t[i] = sBox[s[i]];
			for (int c = 0; c < 4; c++)
				for (int r = 0; r < 4; r++)
					s[r + 4 * c] = t[r + 4 * ((c + r) % 4)];
			if (round != 10)
			begin
				for (int c = 0; c < 4; c++)
				begin
					t[0] = s[4 * c];
					t[1] = s[4 * c + 1];
					t[2] = s[4 * c + 2];
					t[3] = s[4 * c + 3];
					s[4 * c] = gfMul(t[0], 4'd2) ^ gfMul(t[1], 4'd3) ^ t[2] ^ t[3];
					s[4 * c + 1] = t[0] ^ gfMul(t[1], 4'd2) ^ gfMul(t[2], 4'd3) ^ t[3];
					s[4 * c + 2] = t[0] ^ t[1] ^ gfMul(t[2], 4'd2) ^ gfMul(t[3], 4'd3);
					s[4 * c + 3] = gfMul(t[0], 4'd3) ^ t[1] ^ t[2] ^ gfMul(t[3], 4'd2);
				end
			end
			for (int i = 0; i < 16; i++)
				s[i] = s[i] ^ w[16 * round + i];
		end
		for (int i = 0; i < 16; i++)
			out[i] = s[i];
		return out;
	endfunction

	// ========================================================================
	// Checks
	// ========================================================================

	task automatic abortRun(input string reason);
		$display("%s", reason);
		$display("RESULT: FAIL");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic compareBlock(input string name, input aesBlock expected, input aesBlock actual);
		if (actual !== expected)
			abortRun($sformatf("ERR %s expected %h actual %h", name, expected, actual));
	endtask

	task automatic compareLatency(input string name, input int expected, input int actual);
		if (actual != expected)
			abortRun($sformatf("ERR %s expected %0d actual %0d", name, expected, actual));
	endtask

	task automatic compareFlag(input string name, input logic expected, input logic actual);
		if (actual !== expected)
			abortRun($sformatf("ERR %s expected %b actual %b", name, expected, actual));
	endtask

	always @(posedge clock)
	begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= cycleLimit)
			abortRun($sformatf("Timeout: the tests did not finish within %0d cycles", cycleLimit));
	end

	// One run from start to done. A nonzero pulseAt pulses start with the other mode mid-run.
	task automatic runCipher(input aesBlock keyVal, input aesBlock block, input logic enc,
		input int pulseAt, output aesBlock result, output int cycles);
		@(negedge clock);
		key = keyVal;
		messageIn = block;
		encrypt = enc;
		start = 1'b1;
		@(negedge clock);
		start = 1'b0;
		cycles = 0;
		compareFlag("done falls after start", 1'b0, done);
		while (!done)
		begin
			@(negedge clock);
			cycles++;
			start = (cycles == pulseAt);
			encrypt = (cycles == pulseAt) ? !enc : enc;
		end
		start = 1'b0;
		encrypt = enc;
		result = messageOut;
	endtask

	// ========================================================================
	// Test sequence
	// ========================================================================

	initial
	begin
		aesBlock result;
		aesBlock cipher;
		aesBlock keyVal;
		aesBlock plain;
		aesBlock held;
		int cycles;
		int propFails;
		lcgState = 32'hd650;
		reset = 1'b1;
		start = 1'b0;
		encrypt = 1'b1;
		key = '0;
		messageIn = '0;
		repeat (8) @(negedge clock);
		reset = 1'b0;
		compareFlag("done after reset", 1'b0, done);
		compareBlock("messageOut after reset", '0, messageOut);

		runCipher(fipsKey, fipsPlain, 1'b1, 0, result, cycles);
		compareBlock("fips encrypt", fipsCipher, result);
		compareLatency("fips encrypt latency", expectedLatency, cycles);
		runCipher(fipsKey, fipsCipher, 1'b0, 0, result, cycles);
		compareBlock("fips decrypt", fipsPlain, result);
		compareLatency("fips decrypt latency", expectedLatency, cycles);

		for (int n = 0; n < 16; n++)
		begin
			keyVal = randomBlock();
			plain = randomBlock();
			runCipher(keyVal, plain, 1'b1, 0, result, cycles);
			compareBlock($sformatf("random encrypt %0d", n), aesEncryptRef(keyVal, plain), result);
			compareLatency($sformatf("random encrypt latency %0d", n), expectedLatency, cycles);
		end

		for (int n = 0; n < 16; n++)
		begin
			keyVal = randomBlock();
			plain = randomBlock();
			runCipher(keyVal, plain, 1'b1, 0, cipher, cycles);
			runCipher(keyVal, cipher, 1'b0, 0, result, cycles);
			compareBlock($sformatf("round trip %0d", n), plain, result);
			compareLatency($sformatf("round trip latency %0d", n), expectedLatency, cycles);
		end

		// A start in mid-run has to be ignored.
		keyVal = randomBlock();
		plain = randomBlock();
		runCipher(keyVal, plain, 1'b1, 20, result, cycles);
		compareBlock("start during run", aesEncryptRef(keyVal, plain), result);
		compareLatency("start during run latency", expectedLatency, cycles);

		held = messageOut;
		repeat (6)
		begin
			@(negedge clock);
			messageIn = randomBlock();
			compareFlag("done holds", 1'b1, done);
			compareBlock("messageOut holds", held, messageOut);
		end

		propFails = dut_i.props_i.resetFails + dut_i.props_i.fallFails
			+ dut_i.props_i.latencyFails;
		if (propFails == 0)
		begin
			$display("RESULT: PASS");
			$finish;
		end
		else
			abortRun($sformatf("%0d timing assertions failed", propFails));
	end

endmodule

`default_nettype wire

/* aesCore.f */
verilog/aesPkg.sv
verilog/aesCtrlPkg.sv
verilog/aesIfs.sv
verilog/aesKeyExpansion.sv
verilog/aesRoundUnit.sv
verilog/aesController.sv
verilog/aesCore.sv
sim/aesCore_props.sv
sim/aesCoreTb.sv

/* runSim.sh */
#!/usr/bin/env bash
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --assert -j 0 --top-module aesCoreTb -f aesCore.f -o aesCoreSim
./obj_dir/aesCoreSim +verilator+error+limit+100 | tee sim.log

if grep -qx "RESULT: PASS" sim.log; then
	exit 0
fi
exit 1
